/* hw/mini_core_params.svh */
`ifndef MINI_CORE_PARAMS_SVH
`define MINI_CORE_PARAMS_SVH

`define MC_XLEN         32
`define MC_RADDR_W      5
`define MC_IMEM_DEPTH   64
`define MC_PC_W         6
`define MC_INBUF_DEPTH  8

// primary opcodes
`define MC_OP_SPECIAL   6'b000000
`define MC_OP_ADDI      6'b001000
`define MC_OP_BEQ       6'b000100
`define MC_OP_BNE       6'b000101
`define MC_OP_J         6'b000010

// funct field under special
`define MC_FN_ADD       6'b100000
`define MC_FN_SUB       6'b100010
`define MC_FN_IN        6'b101010
`define MC_FN_OUT       6'b010101
`define MC_FN_RET       6'b000000

`endif

/* hw/mini_core_pkg.sv */
`default_nettype none

`include "mini_core_params.svh"

package mini_core_pkg;

    // register-register view
    typedef struct packed {
        logic [5:0]             op;
        logic [`MC_RADDR_W-1:0] rs;
        logic [`MC_RADDR_W-1:0] rt;
        logic [`MC_RADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } instr_r_t;

    // immediate view, also carries the jump target in its low bits
    typedef struct packed {
        logic [5:0]             op;
        logic [`MC_RADDR_W-1:0] rs;
        logic [`MC_RADDR_W-1:0] rt;
        logic [15:0]            imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    typedef enum logic [1:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_CMP
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_REG,
        WB_OUT,
        WB_HALT
    } wb_kind_t;

endpackage

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mini_core_params.svh"

module fetch_stage (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire                     run,
    input  wire                     halted,
    input  wire                     stall,
    input  wire                     flush,
    input  wire                     redirect,
    input  wire [`MC_PC_W-1:0]      redirect_pc,
    input  wire                     prog_we,
    input  wire [`MC_PC_W-1:0]      prog_addr,
    input  wire [`MC_XLEN-1:0]      prog_data,
    output logic                    f_valid,
    output mini_core_pkg::instr_t   f_instr,
    output logic [`MC_PC_W-1:0]     f_pc
);
    import mini_core_pkg::*;

    logic [`MC_XLEN-1:0] imem [`MC_IMEM_DEPTH];
    logic [`MC_PC_W-1:0] pc;
    logic [`MC_PC_W-1:0] next_pc;
    instr_t              cur;
    logic                advance;

    assign cur     = imem[pc];
    assign advance = run & ~halted & ~stall;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // branches always predicted taken, pc arithmetic wraps at the memory size
    always_comb begin
        case (cur.r.op)
            `MC_OP_BEQ, `MC_OP_BNE: next_pc = pc + cur.i.imm[`MC_PC_W-1:0];
            `MC_OP_J:               next_pc = cur.i.imm[`MC_PC_W-1:0];
            default:                next_pc = pc + 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc      <= '0;
            f_valid <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (advance) begin
                pc <= next_pc;
            end
            if (flush) begin
                f_valid <= 1'b0;
            end else if (!stall) begin
                f_valid <= run & ~halted;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            f_instr <= cur;
            f_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mini_core_params.svh"

module decode_stage (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         stall,
    input  wire                         flush,
    input  wire                         f_valid,
    input  mini_core_pkg::instr_t       f_instr,
    input  wire [`MC_PC_W-1:0]          f_pc,
    input  wire                         word_avail,
    input  wire [`MC_XLEN-1:0]          word_data,
    input  wire                         wb_en,
    input  wire [`MC_RADDR_W-1:0]       wb_rd,
    input  wire [`MC_XLEN-1:0]          wb_data,
    output logic                        word_take,
    output logic                        d_valid,
    output mini_core_pkg::instr_t       d_instr,
    output logic [`MC_PC_W-1:0]         d_pc,
    output logic [`MC_XLEN-1:0]         d_a,
    output logic [`MC_XLEN-1:0]         d_b,
    output mini_core_pkg::alu_op_t      d_alu_op,
    output mini_core_pkg::wb_kind_t     d_wb_kind,
    output logic [`MC_RADDR_W-1:0]      d_rd,
    output logic                        d_hold
);
    import mini_core_pkg::*;

    localparam int NREG = 1 << `MC_RADDR_W;

    logic [`MC_XLEN-1:0]    rf [NREG];
    logic [NREG-1:0]        busy;
    logic [`MC_RADDR_W-1:0] rs, rt, dest;
    logic [`MC_XLEN-1:0]    rs_val, rt_val, opnd_a, opnd_b;
    logic                   use_rs, use_rt, has_dest, is_in;
    logic                   hazard, issue;
    alu_op_t                alu_op;
    wb_kind_t               wb_kind;

    assign rs = f_instr.r.rs;
    assign rt = f_instr.r.rt;

    // r0 reads as zero
    assign rs_val = (rs == '0) ? '0 : rf[rs];
    assign rt_val = (rt == '0) ? '0 : rf[rt];

    // ****************************************
    // instruction decode
    // ****************************************
    always_comb begin
        use_rs   = 1'b0;
        use_rt   = 1'b0;
        has_dest = 1'b0;
        is_in    = 1'b0;
        dest     = f_instr.r.rd;
        opnd_a   = rs_val;
        opnd_b   = rt_val;
        alu_op   = ALU_PASS;
        wb_kind  = WB_NONE;
        case (f_instr.r.op)
            `MC_OP_SPECIAL: begin
                case (f_instr.r.funct)
                    `MC_FN_ADD, `MC_FN_SUB: begin
                        use_rs   = 1'b1;
                        use_rt   = 1'b1;
                        has_dest = 1'b1;
                        alu_op   = (f_instr.r.funct == `MC_FN_ADD) ? ALU_ADD : ALU_SUB;
                        wb_kind  = WB_REG;
                    end
                    `MC_FN_IN: begin
                        // in writes the rs field
                        is_in    = 1'b1;
                        has_dest = 1'b1;
                        dest     = rs;
                        opnd_a   = word_data;
                        wb_kind  = WB_REG;
                    end
                    `MC_FN_OUT: begin
                        use_rs  = 1'b1;
                        wb_kind = WB_OUT;
                    end
                    `MC_FN_RET: wb_kind = WB_HALT;
                    default: ;
                endcase
            end
            `MC_OP_ADDI: begin
                use_rs   = 1'b1;
                has_dest = 1'b1;
                dest     = f_instr.i.rt;
                opnd_b   = {{(`MC_XLEN-16){f_instr.i.imm[15]}}, f_instr.i.imm};
                alu_op   = ALU_ADD;
                wb_kind  = WB_REG;
            end
            `MC_OP_BEQ, `MC_OP_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                alu_op = ALU_CMP;
            end
            default: ;
        endcase
    end

    // raw and waw on the scoreboard, or in without a full word
    assign hazard = (use_rs & busy[rs]) | (use_rt & busy[rt]) |
                    (has_dest & busy[dest]) | (is_in & ~word_avail);
    assign issue     = f_valid & ~hazard & ~stall & ~flush;
    assign word_take = issue & is_in;
    assign d_hold    = stall | (f_valid & hazard);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= '0;
            d_valid <= 1'b0;
        end else begin
            if (wb_en) begin
                busy[wb_rd] <= 1'b0;
            end
            if (issue && has_dest && dest != '0) begin
                busy[dest] <= 1'b1;
            end
            if (!stall) begin
                d_valid <= issue;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_en) begin
            rf[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            d_instr   <= f_instr;
            d_pc      <= f_pc;
            d_a       <= opnd_a;
            d_b       <= opnd_b;
            d_alu_op  <= alu_op;
            d_wb_kind <= wb_kind;
            d_rd      <= dest;
        end
    end

endmodule

`default_nettype wire

/* hw/input_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mini_core_params.svh"

module input_buffer (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 in_valid,
    input  wire [7:0]           in_data,
    input  wire                 word_take,
    output logic                in_ready,
    output logic                word_avail,
    output logic [`MC_XLEN-1:0] word_data
);

    localparam int PTR_W = $clog2(`MC_INBUF_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] DEPTH      = `MC_INBUF_DEPTH;
    localparam logic [CNT_W-1:0] WORD_BYTES = 4;

    logic [7:0]       mem [`MC_INBUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count, count_next;
    logic             push;

    assign push       = in_valid & in_ready;
    assign word_avail = count >= WORD_BYTES;

    // oldest byte lands in the low end
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            word_data[8*k +: 8] = mem[rd_ptr + PTR_W'(k)];
        end
    end

    always_comb begin
        count_next = count;
        if (push) begin
            count_next = count_next + 1'b1;
        end
        if (word_take) begin
            count_next = count_next - WORD_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            count    <= count_next;
            in_ready <= count_next != DEPTH;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (word_take) begin
                rd_ptr <= rd_ptr + PTR_W'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

/* hw/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mini_core_params.svh"

module execute_stage (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         stall,
    input  wire                         d_valid,
    input  mini_core_pkg::instr_t       d_instr,
    input  wire [`MC_PC_W-1:0]          d_pc,
    input  wire [`MC_XLEN-1:0]          d_a,
    input  wire [`MC_XLEN-1:0]          d_b,
    input  mini_core_pkg::alu_op_t      d_alu_op,
    input  mini_core_pkg::wb_kind_t     d_wb_kind,
    input  wire [`MC_RADDR_W-1:0]       d_rd,
    output logic                        e_valid,
    output logic [`MC_XLEN-1:0]         e_result,
    output mini_core_pkg::wb_kind_t     e_wb_kind,
    output logic [`MC_RADDR_W-1:0]      e_rd,
    output logic                        redirect,
    output logic [`MC_PC_W-1:0]         redirect_pc,
    output logic                        flush
);
    import mini_core_pkg::*;

    logic                equal;
    logic                is_beq, is_bne;
    logic                mispredict;
    logic [`MC_XLEN-1:0] alu_out;

    assign equal  = d_a == d_b;
    assign is_beq = d_instr.r.op == `MC_OP_BEQ;
    assign is_bne = d_instr.r.op == `MC_OP_BNE;

    // fetch already went to the target, so only a fall-through is wrong
    assign mispredict  = d_valid & ~stall & ((is_beq & ~equal) | (is_bne & equal));
    assign redirect    = mispredict;
    assign flush       = mispredict;
    assign redirect_pc = d_pc + 1'b1;

    always_comb begin
        case (d_alu_op)
            ALU_ADD: alu_out = d_a + d_b;
            ALU_SUB: alu_out = d_a - d_b;
            ALU_CMP: alu_out = {{(`MC_XLEN-1){1'b0}}, equal};
            default: alu_out = d_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            e_valid <= 1'b0;
        end else if (!stall) begin
            e_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            e_result  <= alu_out;
            e_wb_kind <= d_wb_kind;
            e_rd      <= d_rd;
        end
    end

endmodule

`default_nettype wire

/* hw/writeback_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mini_core_params.svh"

module writeback_stage (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         e_valid,
    input  wire [`MC_XLEN-1:0]          e_result,
    input  mini_core_pkg::wb_kind_t     e_wb_kind,
    input  wire [`MC_RADDR_W-1:0]       e_rd,
    input  wire                         out_ready,
    output logic                        wb_en,
    output logic [`MC_RADDR_W-1:0]      wb_rd,
    output logic [`MC_XLEN-1:0]         wb_data,
    output logic                        out_valid,
    output logic [`MC_XLEN-1:0]         out_data,
    output logic                        stall,
    output logic                        halted
);
    import mini_core_pkg::*;

    logic take;

    // a word waiting on the output freezes the whole pipeline
    assign stall = out_valid & ~out_ready;
    assign take  = e_valid & ~stall & ~halted;

    assign wb_en   = take & (e_wb_kind == WB_REG);
    assign wb_rd   = e_rd;
    assign wb_data = e_result;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            halted    <= 1'b0;
        end else begin
            if (take && e_wb_kind == WB_OUT) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (take && e_wb_kind == WB_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && e_wb_kind == WB_OUT) begin
            out_data <= e_result;
        end
    end

endmodule

`default_nettype wire

/* hw/mini_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mini_core_params.svh"

module mini_core (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 run,
    input  wire                 prog_we,
    input  wire [`MC_PC_W-1:0]  prog_addr,
    input  wire [`MC_XLEN-1:0]  prog_data,
    input  wire                 in_valid,
    input  wire [7:0]           in_data,
    output wire                 in_ready,
    output wire                 out_valid,
    output wire [`MC_XLEN-1:0]  out_data,
    input  wire                 out_ready,
    output wire                 halted
);
    import mini_core_pkg::*;

    // ****************************************
    // inter-stage nets
    // ****************************************
    wire                    stall, flush, redirect, d_hold;
    wire [`MC_PC_W-1:0]     redirect_pc;
    wire                    f_valid, d_valid, e_valid;
    instr_t                 f_instr, d_instr;
    wire [`MC_PC_W-1:0]     f_pc, d_pc;
    wire                    word_avail, word_take;
    wire [`MC_XLEN-1:0]     word_data;
    wire [`MC_XLEN-1:0]     d_a, d_b, e_result, wb_data;
    alu_op_t                d_alu_op;
    wb_kind_t               d_wb_kind, e_wb_kind;
    wire [`MC_RADDR_W-1:0]  d_rd, e_rd, wb_rd;
    wire                    wb_en;

    // fetch holds on d_hold, which already covers the output stall
    fetch_stage u_fetch (
        .clk(clk), .rstn(rstn), .run(run), .halted(halted), .stall(d_hold),
        .flush(flush), .redirect(redirect), .redirect_pc(redirect_pc),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .f_valid(f_valid), .f_instr(f_instr), .f_pc(f_pc)
    );

    decode_stage u_decode (
        .clk(clk), .rstn(rstn), .stall(stall), .flush(flush),
        .f_valid(f_valid), .f_instr(f_instr), .f_pc(f_pc),
        .word_avail(word_avail), .word_data(word_data),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .word_take(word_take),
        .d_valid(d_valid), .d_instr(d_instr), .d_pc(d_pc), .d_a(d_a), .d_b(d_b),
        .d_alu_op(d_alu_op), .d_wb_kind(d_wb_kind), .d_rd(d_rd), .d_hold(d_hold)
    );

    input_buffer u_input_buffer (
        .clk(clk), .rstn(rstn), .in_valid(in_valid), .in_data(in_data),
        .word_take(word_take), .in_ready(in_ready),
        .word_avail(word_avail), .word_data(word_data)
    );

    execute_stage u_execute (
        .clk(clk), .rstn(rstn), .stall(stall),
        .d_valid(d_valid), .d_instr(d_instr), .d_pc(d_pc), .d_a(d_a), .d_b(d_b),
        .d_alu_op(d_alu_op), .d_wb_kind(d_wb_kind), .d_rd(d_rd),
        .e_valid(e_valid), .e_result(e_result), .e_wb_kind(e_wb_kind), .e_rd(e_rd),
        .redirect(redirect), .redirect_pc(redirect_pc), .flush(flush)
    );

    writeback_stage u_writeback (
        .clk(clk), .rstn(rstn), .e_valid(e_valid), .e_result(e_result),
        .e_wb_kind(e_wb_kind), .e_rd(e_rd), .out_ready(out_ready),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .out_valid(out_valid), .out_data(out_data), .stall(stall), .halted(halted)
    );

endmodule

`default_nettype wire

/* testbench/tb_mini_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mini_core_params.svh"

module tb_mini_core;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_ITEMS  = 64;

    logic                   clk;
    logic                   rstn;
    logic                   run;
    logic                   prog_we;
    logic [`MC_PC_W-1:0]    prog_addr;
    logic [`MC_XLEN-1:0]    prog_data;
    logic                   in_valid;
    logic [7:0]             in_data;
    logic                   in_ready;
    logic                   out_valid;
    logic [`MC_XLEN-1:0]    out_data;
    logic                   out_ready;
    logic                   halted;

    // tables filled from the data file
    logic [`MC_XLEN-1:0]    prog_words [MAX_ITEMS];
    logic [7:0]             in_bytes [MAX_ITEMS];
    logic [`MC_XLEN-1:0]    exp_words [MAX_ITEMS];
    int                     n_prog;
    int                     n_in;
    int                     n_exp;
    int                     duty;
    int                     in_idx;
    int                     out_idx;
    logic                   loaded;
    integer                 seed;
    integer                 rnd;

    mini_core u_mini_core (
        .clk(clk), .rstn(rstn), .run(run),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .in_valid(in_valid), .in_data(in_data), .in_ready(in_ready),
        .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
        .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // helpers
    // ****************************************
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at time %0t: %s = 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
        end
    endtask

    // one tag and one value per entry
    // # starts a comment up to end of line
    task automatic read_stimulus();
        integer           fd;
        integer           code;
        logic [8*8-1:0]   tag;
        logic [8*128-1:0] rest;
        logic [31:0]      value;
        fd = $fopen("testbench/tb_mini_core_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open testbench/tb_mini_core_input.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
                if (tag == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "D") begin
                    code = $fscanf(fd, "%d", value);
                    duty = value;
                end else begin
                    code = $fscanf(fd, "%h", value);
                    if (tag == "P") begin
                        prog_words[n_prog] = value;
                        n_prog++;
                    end else if (tag == "I") begin
                        in_bytes[n_in] = value[7:0];
                        n_in++;
                    end else if (tag == "E") begin
                        exp_words[n_exp] = value;
                        n_exp++;
                    end else begin
                        abort_run("unknown entry tag in the stimulus file");
                    end
                end
            end
        end
        $fclose(fd);
        if (n_prog > MAX_ITEMS || n_in > MAX_ITEMS || n_exp > MAX_ITEMS) begin
            abort_run("the stimulus file holds more entries than the tables");
        end
    endtask

    task automatic load_program();
        for (int k = 0; k < n_prog; k++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = `MC_PC_W'(k);
            prog_data = prog_words[k];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // ****************************************
    // main sequence
    // ****************************************
    initial begin
        seed      = 32'h46290079;
        rstn      = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        n_prog    = 0;
        n_in      = 0;
        n_exp     = 0;
        duty      = 100;
        in_idx    = 0;
        out_idx   = 0;
        loaded    = 1'b0;
        read_stimulus();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        // outputs held low by reset
        check_value("in_ready", in_ready, 0);
        check_value("out_valid", out_valid, 0);
        check_value("halted", halted, 0);
        rstn = 1'b1;
        load_program();
        run = 1'b1;
        while (!halted) @(negedge clk);
        // a few more cycles to catch a stray word after halt
        repeat (10) @(negedge clk);
        check_value("output count", out_idx, n_exp);
        check_value("accepted input bytes", in_idx, n_in);
        $display("Simulation completed successfully");
        $finish;
    end

    // input bytes with random gaps, random out_ready, output checks
    initial begin
        @(posedge rstn);
        forever begin
            @(negedge clk);
            // no bytes leave the fifo before run
            if (!run) begin
                check_value("in_ready", in_ready, in_idx < `MC_INBUF_DEPTH);
            end
            rnd       = $random(seed);
            out_ready = ((rnd & 32'h7fff_ffff) % 100) < duty;
            rnd       = $random(seed);
            in_valid  = (in_idx < n_in) && ((rnd & 3) != 0);
            in_data   = (in_idx < n_in) ? in_bytes[in_idx] : 8'h00;
            // in_ready and out_valid only move on the rising edge
            if (in_valid && in_ready) begin
                in_idx++;
            end
            if (halted && out_valid) begin
                abort_run("out_valid was raised after the core halted");
            end
            if (out_valid && out_ready) begin
                if (out_idx >= n_exp) begin
                    abort_run("the core sent more output words than expected");
                end else begin
                    check_value("out_data", out_data, exp_words[out_idx]);
                    out_idx++;
                end
            end
        end
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (200 * n_prog + 50 * n_in) @(posedge clk);
        abort_run("watchdog expired, the core did not halt in time");
    end

endmodule

`default_nettype wire

/* testbench/tb_mini_core_input.txt */
# columns: tag value. P program word (hex), I input byte (hex)
# E expected output word (hex), D out_ready duty in percent (decimal)
D 60
P 0020002A # 0: in r1
P 00200015 # 1: out r1
P 20020005 # 2: addi r2, r0, 5
P 20430007 # 3: addi r3, r2, 7
P 00622020 # 4: add r4, r3, r2
P 00812822 # 5: sub r5, r4, r1
P 00800015 # 6: out r4
P 00A00015 # 7: out r5
P 10430003 # 8: beq r2, r3, +3 (not taken)
P 14430003 # 9: bne r2, r3, +3 (taken)
P 00400015 # 10: out r2 (skipped)
P 00600015 # 11: out r3 (wrong path of beq)
P 10840002 # 12: beq r4, r4, +2 (taken)
P 00200015 # 13: out r1 (skipped)
P 14420003 # 14: bne r2, r2, +3 (not taken)
P 00C0002A # 15: in r6
P 08000012 # 16: j 18
P 00400015 # 17: out r2 (skipped)
P 00E0002A # 18: in r7
P 00C74020 # 19: add r8, r6, r7
P 00C00015 # 20: out r6
P 01000015 # 21: out r8
P 00000000 # 22: ret
P 00000000 # 23: ret pad
P 00000000 # 24: ret pad
P 00000000 # 25: ret pad
I 78
I 56
I 34
I 12
I EF
I BE
I AD
I DE
I 01
I 02
I 03
I 04
E 12345678
E 00000011
E EDCBA999
E DEADBEEF
E E2B0C0F0

/* mini_core.f */
+incdir+hw
hw/mini_core_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/input_buffer.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/mini_core.sv
testbench/tb_mini_core.sv

/* Bender.yml */
package:
  name: mini_core

export_include_dirs:
  - hw

sources:
  - hw/mini_core_pkg.sv
  - hw/fetch_stage.sv
  - hw/decode_stage.sv
  - hw/input_buffer.sv
  - hw/execute_stage.sv
  - hw/writeback_stage.sv
  - hw/mini_core.sv
  - target: test
    files:
      - testbench/tb_mini_core.sv
